// File: hw/core_pkg.sv
/*
 * shared definitions of the core
 * widths, word types, major opcodes, ALU operations
 * and the structs passed between pipeline stages
 */

package core_pkg;

  localparam int unsigned XLEN    = 32;
  localparam int unsigned NR_REGS = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [31:0]     addr_t;
  typedef logic [31:0]     instr_t;
  typedef logic [4:0]      reg_addr_t;

  localparam addr_t BOOT_ADDR   = 32'h0000_0000;
  localparam addr_t INSTR_BYTES = 32'd4;

  // major opcodes
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPCODE_LUI    = 7'b0110111;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_PASS_B
  } alu_op_e;

  // ----------------------------------------
  // stage structs
  // ----------------------------------------
  typedef struct packed {
    logic  cyc;
    logic  stb;
    addr_t adr;
  } wb_req_t;

  typedef struct packed {
    logic   valid;
    addr_t  pc;
    instr_t instr;
  } fetch_entry_t;

  // pc travels along for the commit report
  typedef struct packed {
    logic      valid;
    addr_t     pc;
    alu_op_e   alu_op;
    reg_addr_t rd;
    logic      we;
    xlen_t     op_a;
    xlen_t     op_b;
    logic      illegal;
  } issue_entry_t;

  typedef struct packed {
    logic      valid;
    addr_t     pc;
    reg_addr_t rd;
    logic      we;
    xlen_t     result;
    logic      illegal;
  } commit_entry_t;

endpackage

// File: hw/fetch_stage.sv
/*
 * instruction fetch over a Wishbone classic master port
 * PC counter, idle/request FSM, one-entry instruction buffer
 */

`timescale 1ns/1ps

module fetch_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  output core_pkg::wb_req_t      wb_req_o,
  input  logic                   wb_ack_i,
  input  core_pkg::instr_t       wb_dat_i,
  output core_pkg::fetch_entry_t fetch_o,
  input  logic                   decode_ready_i
);

  typedef enum logic {
    FETCH_IDLE,
    FETCH_REQ
  } fetch_state_e;

  fetch_state_e           state_q, state_d;
  core_pkg::addr_t        pc_q;
  core_pkg::fetch_entry_t buf_q;
  logic                   take;
  logic                   buf_free;
  logic                   ack;

  // buffer is free when empty or drained this cycle
  assign take     = buf_q.valid & decode_ready_i;
  assign buf_free = ~buf_q.valid | take;
  assign ack      = (state_q == FETCH_REQ) & wb_ack_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH_IDLE: begin
        if (buf_free) begin
          state_d = FETCH_REQ;
        end
      end
      FETCH_REQ: begin
        // drop cyc/stb for one cycle after ack
        if (wb_ack_i) begin
          state_d = FETCH_IDLE;
        end
      end
      default: state_d = FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FETCH_IDLE;
      pc_q    <= core_pkg::BOOT_ADDR;
      buf_q   <= '0;
    end else begin
      state_q <= state_d;
      if (ack) begin
        pc_q        <= pc_q + core_pkg::INSTR_BYTES;
        buf_q.valid <= 1'b1;
        buf_q.pc    <= pc_q;
        buf_q.instr <= wb_dat_i;
      end else if (take) begin
        buf_q.valid <= 1'b0;
      end
    end
  end

  always_comb begin
    wb_req_o.cyc = (state_q == FETCH_REQ);
    wb_req_o.stb = (state_q == FETCH_REQ);
    wb_req_o.adr = pc_q;
  end

  assign fetch_o = buf_q;

endmodule

// File: hw/regfile.sv
/*
 * integer register file, 32 x 32
 * two asynchronous reads with write-through, one write port
 */

`timescale 1ns/1ps

module regfile (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  core_pkg::reg_addr_t raddr_a_i,
  input  core_pkg::reg_addr_t raddr_b_i,
  output core_pkg::xlen_t     rdata_a_o,
  output core_pkg::xlen_t     rdata_b_o,
  input  logic                we_i,
  input  core_pkg::reg_addr_t waddr_i,
  input  core_pkg::xlen_t     wdata_i
);

  core_pkg::xlen_t [core_pkg::NR_REGS-1:0] regs_q;
  logic                                    write_en;

  // x0 is never written, so it reads as zero
  assign write_en = we_i & (waddr_i != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      regs_q <= '0;
    end else if (write_en) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // write in progress wins over the stored value
  assign rdata_a_o = (write_en && raddr_a_i == waddr_i) ? wdata_i : regs_q[raddr_a_i];
  assign rdata_b_o = (write_en && raddr_b_i == waddr_i) ? wdata_i : regs_q[raddr_b_i];

endmodule

// File: hw/decode_stage.sv
/*
 * instruction decode and operand selection
 * read-after-write stall against the execute input register
 */

`timescale 1ns/1ps

module decode_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  core_pkg::fetch_entry_t fetch_i,
  output logic                   decode_ready_o,
  output core_pkg::reg_addr_t    raddr_a_o,
  output core_pkg::reg_addr_t    raddr_b_o,
  input  core_pkg::xlen_t        rdata_a_i,
  input  core_pkg::xlen_t        rdata_b_i,
  output core_pkg::issue_entry_t issue_o
);

  core_pkg::instr_t       instr;
  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  core_pkg::reg_addr_t    rs1, rs2;
  core_pkg::xlen_t        imm_i, imm_u;
  core_pkg::issue_entry_t issue_d, issue_q;
  logic                   hazard;

  assign instr  = fetch_i.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign imm_i  = {{20{instr[31]}}, instr[31:20]};
  assign imm_u  = {instr[31:12], 12'b0};

  assign raddr_a_o = rs1;
  assign raddr_b_o = rs2;

  // ----------------------------------------
  // hazard against the entry in execute
  // ----------------------------------------
  assign hazard = fetch_i.valid & issue_q.valid & issue_q.we & (issue_q.rd != '0) &
                  ((rs1 == issue_q.rd) | (rs2 == issue_q.rd));
  assign decode_ready_o = ~hazard;

  always_comb begin
    issue_d         = '0;
    issue_d.pc      = fetch_i.pc;
    issue_d.rd      = instr[11:7];
    issue_d.op_a    = rdata_a_i;
    issue_d.op_b    = rdata_b_i;
    issue_d.alu_op  = core_pkg::ALU_ADD;
    issue_d.we      = 1'b1;
    case (opcode)
      core_pkg::OPCODE_OP: begin
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  issue_d.alu_op = core_pkg::ALU_ADD;
            3'b001:  issue_d.alu_op = core_pkg::ALU_SLL;
            3'b100:  issue_d.alu_op = core_pkg::ALU_XOR;
            3'b101:  issue_d.alu_op = core_pkg::ALU_SRL;
            3'b110:  issue_d.alu_op = core_pkg::ALU_OR;
            3'b111:  issue_d.alu_op = core_pkg::ALU_AND;
            default: issue_d.illegal = 1'b1;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          issue_d.alu_op = core_pkg::ALU_SUB;
        end else begin
          issue_d.illegal = 1'b1;
        end
      end
      core_pkg::OPCODE_OP_IMM: begin
        issue_d.op_b = imm_i;
        case (funct3)
          3'b000:  issue_d.alu_op = core_pkg::ALU_ADD;
          3'b100:  issue_d.alu_op = core_pkg::ALU_XOR;
          3'b110:  issue_d.alu_op = core_pkg::ALU_OR;
          3'b111:  issue_d.alu_op = core_pkg::ALU_AND;
          default: issue_d.illegal = 1'b1;
        endcase
      end
      core_pkg::OPCODE_LUI: begin
        issue_d.op_b   = imm_u;
        issue_d.alu_op = core_pkg::ALU_PASS_B;
      end
      default: issue_d.illegal = 1'b1;
    endcase
    // illegal entries retire without a write
    if (issue_d.illegal) begin
      issue_d.we = 1'b0;
    end
    // bubble while stalled
    issue_d.valid = fetch_i.valid & ~hazard;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_q <= '0;
    end else begin
      issue_q <= issue_d;
    end
  end

  assign issue_o = issue_q;

endmodule

// File: hw/execute_stage.sv
/*
 * single-cycle ALU and execute result register
 */

`timescale 1ns/1ps

module execute_stage (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  core_pkg::issue_entry_t  issue_i,
  output core_pkg::commit_entry_t commit_entry_o
);

  core_pkg::xlen_t        result;
  logic [4:0]             shamt;
  core_pkg::commit_entry_t entry_q;

  assign shamt = issue_i.op_b[4:0];

  always_comb begin
    case (issue_i.alu_op)
      core_pkg::ALU_ADD:    result = issue_i.op_a + issue_i.op_b;
      core_pkg::ALU_SUB:    result = issue_i.op_a - issue_i.op_b;
      core_pkg::ALU_AND:    result = issue_i.op_a & issue_i.op_b;
      core_pkg::ALU_OR:     result = issue_i.op_a | issue_i.op_b;
      core_pkg::ALU_XOR:    result = issue_i.op_a ^ issue_i.op_b;
      core_pkg::ALU_SLL:    result = issue_i.op_a << shamt;
      core_pkg::ALU_SRL:    result = issue_i.op_a >> shamt;
      core_pkg::ALU_PASS_B: result = issue_i.op_b;
      default:              result = issue_i.op_b;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      entry_q <= '0;
    end else begin
      entry_q.valid   <= issue_i.valid;
      entry_q.pc      <= issue_i.pc;
      entry_q.rd      <= issue_i.rd;
      entry_q.we      <= issue_i.we;
      entry_q.result  <= result;
      entry_q.illegal <= issue_i.illegal;
    end
  end

  assign commit_entry_o = entry_q;

endmodule

// File: hw/commit_stage.sv
/*
 * commit: register-file write-back, retirement report
 * and retired-instruction counter
 */

`timescale 1ns/1ps

module commit_stage (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  core_pkg::commit_entry_t entry_i,
  output logic                    rf_we_o,
  output core_pkg::reg_addr_t     rf_waddr_o,
  output core_pkg::xlen_t         rf_wdata_o,
  output core_pkg::commit_entry_t commit_o,
  output logic [63:0]             instret_o
);

  core_pkg::commit_entry_t commit_q;
  logic [63:0]             instret_q;

  // write-back straight from the execute result
  assign rf_we_o    = entry_i.valid & entry_i.we & (entry_i.rd != '0);
  assign rf_waddr_o = entry_i.rd;
  assign rf_wdata_o = entry_i.result;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      commit_q  <= '0;
      instret_q <= '0;
    end else begin
      commit_q <= entry_i;
      // illegal encodings do not count as retired
      if (entry_i.valid && !entry_i.illegal) begin
        instret_q <= instret_q + 64'd1;
      end
    end
  end

  assign commit_o  = commit_q;
  assign instret_o = instret_q;

endmodule

// File: hw/mini_core.sv
/*
 * top level of the four-stage RV32 integer core
 * fetch, decode, register file, execute and commit
 */

`timescale 1ns/1ps

module mini_core (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  output core_pkg::wb_req_t       wb_req_o,
  input  logic                    wb_ack_i,
  input  core_pkg::instr_t        wb_dat_i,
  output core_pkg::commit_entry_t commit_o,
  output logic [63:0]             instret_o
);

  // ----------------------------------------
  // stage wires
  // ----------------------------------------
  core_pkg::fetch_entry_t  fetch_entry;
  logic                    decode_ready;
  core_pkg::reg_addr_t     raddr_a, raddr_b;
  core_pkg::xlen_t         rdata_a, rdata_b;
  core_pkg::issue_entry_t  issue_entry;
  core_pkg::commit_entry_t exec_entry;
  logic                    rf_we;
  core_pkg::reg_addr_t     rf_waddr;
  core_pkg::xlen_t         rf_wdata;

  fetch_stage fetch_stage_i (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .wb_req_o       ( wb_req_o     ),
    .wb_ack_i       ( wb_ack_i     ),
    .wb_dat_i       ( wb_dat_i     ),
    .fetch_o        ( fetch_entry  ),
    .decode_ready_i ( decode_ready )
  );

  decode_stage decode_stage_i (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .fetch_i        ( fetch_entry  ),
    .decode_ready_o ( decode_ready ),
    .raddr_a_o      ( raddr_a      ),
    .raddr_b_o      ( raddr_b      ),
    .rdata_a_i      ( rdata_a      ),
    .rdata_b_i      ( rdata_b      ),
    .issue_o        ( issue_entry  )
  );

  regfile regfile_i (
    .clk_i     ( clk_i    ),
    .rst_ni    ( rst_ni   ),
    .raddr_a_i ( raddr_a  ),
    .raddr_b_i ( raddr_b  ),
    .rdata_a_o ( rdata_a  ),
    .rdata_b_o ( rdata_b  ),
    .we_i      ( rf_we    ),
    .waddr_i   ( rf_waddr ),
    .wdata_i   ( rf_wdata )
  );

  execute_stage execute_stage_i (
    .clk_i          ( clk_i       ),
    .rst_ni         ( rst_ni      ),
    .issue_i        ( issue_entry ),
    .commit_entry_o ( exec_entry  )
  );

  commit_stage commit_stage_i (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .entry_i    ( exec_entry ),
    .rf_we_o    ( rf_we      ),
    .rf_waddr_o ( rf_waddr   ),
    .rf_wdata_o ( rf_wdata   ),
    .commit_o   ( commit_o   ),
    .instret_o  ( instret_o  )
  );

endmodule

// File: tb/tb_mini_core.sv
/*
 * testbench for the four-stage core
 * clock and reset, Wishbone instruction memory with random wait states,
 * commit checker against the cases file, retired-instruction count
 */

`timescale 1ns/1ps

module tb_mini_core;

  localparam int NUM_CASES    = 21;
  localparam int CASE_WORDS   = 5;
  localparam int RESET_CYCLES = 8;
  localparam int MAX_CYCLES   = 8 * NUM_CASES + 100;

  logic                    clk    = 1'b0;
  logic                    rst_n  = 1'b0;
  logic                    wb_ack = 1'b0;
  core_pkg::instr_t        wb_dat = '0;
  core_pkg::wb_req_t       wb_req;
  core_pkg::commit_entry_t commit;
  logic [63:0]             instret;

  // five words per case in the order instr, we, rd, result, illegal
  logic [31:0]     case_mem [0:NUM_CASES*CASE_WORDS-1];
  int unsigned     rand_state;
  int              wait_left;
  logic            busy;
  int              fetch_count;
  core_pkg::addr_t exp_adr;
  int              fetch_errors = 0;
  int              commit_idx = 0;
  int              case_base;
  int              case_errs;
  core_pkg::addr_t exp_pc;
  int              cases_passed = 0;
  int              cases_failed = 0;
  int              extra_commits = 0;
  int              cycle_count = 0;
  int              legal_cases;
  int              reset_errs;
  int              instret_errs;
  logic            timed_out;

  mini_core mini_core_i (
    .clk_i     ( clk     ),
    .rst_ni    ( rst_n   ),
    .wb_req_o  ( wb_req  ),
    .wb_ack_i  ( wb_ack  ),
    .wb_dat_i  ( wb_dat  ),
    .commit_o  ( commit  ),
    .instret_o ( instret )
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    if (rst_n) begin
      cycle_count <= cycle_count + 1;
    end
  end

  function automatic int unsigned lcg_step(input int unsigned state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("ERROR %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
  endtask

  task automatic check_idle_outputs();
    if (wb_req.cyc !== 1'b0) begin
      report_mismatch("wb_req_o.cyc", 32'd0, 32'(wb_req.cyc));
      reset_errs++;
    end
    if (wb_req.stb !== 1'b0) begin
      report_mismatch("wb_req_o.stb", 32'd0, 32'(wb_req.stb));
      reset_errs++;
    end
    if (commit.valid !== 1'b0) begin
      report_mismatch("commit_o.valid", 32'd0, 32'(commit.valid));
      reset_errs++;
    end
    if (instret !== 64'd0) begin
      $display("ERROR %0t: instret_o expected 0, got %0d", $time, instret);
      reset_errs++;
    end
  endtask

  // ----------------------------------------
  // instruction memory serving one word per ack
  // ----------------------------------------
  always @(posedge clk) begin
    if (!rst_n) begin
      wb_ack      <= 1'b0;
      busy        = 1'b0;
      wait_left   = 0;
      fetch_count = 0;
      rand_state  = 32'd98861;
    end else if (wb_ack) begin
      // classic cycle ends here and the master drops cyc/stb
      wb_ack      <= 1'b0;
      busy        = 1'b0;
      fetch_count = fetch_count + 1;
    end else if (wb_req.cyc && wb_req.stb && fetch_count < NUM_CASES) begin
      if (!busy) begin
        busy       = 1'b1;
        rand_state = lcg_step(rand_state);
        wait_left  = int'((rand_state >> 16) & 32'd3);
        exp_adr    = core_pkg::BOOT_ADDR + core_pkg::INSTR_BYTES * 32'(fetch_count);
      end
      // address must hold through the wait states
      if (wb_req.adr !== exp_adr) begin
        report_mismatch("wb_req_o.adr", exp_adr, wb_req.adr);
        fetch_errors = fetch_errors + 1;
      end
      if (wait_left == 0) begin
        wb_ack <= 1'b1;
        wb_dat <= case_mem[fetch_count*CASE_WORDS];
      end else begin
        wait_left = wait_left - 1;
      end
    end
  end

  // ----------------------------------------
  // commit monitor in fetch order
  // ----------------------------------------
  always @(negedge clk) begin
    if (rst_n && commit.valid) begin
      if (commit_idx >= NUM_CASES) begin
        $display("unexpected commit of pc %h after the last case", commit.pc);
        extra_commits = extra_commits + 1;
      end else begin
        case_base = commit_idx * CASE_WORDS;
        case_errs = 0;
        exp_pc    = core_pkg::BOOT_ADDR + core_pkg::INSTR_BYTES * 32'(commit_idx);
        if (commit.pc !== exp_pc) begin
          report_mismatch("commit_o.pc", exp_pc, commit.pc);
          case_errs++;
        end
        if (commit.we !== case_mem[case_base+1][0]) begin
          report_mismatch("commit_o.we", case_mem[case_base+1], 32'(commit.we));
          case_errs++;
        end
        if (commit.rd !== case_mem[case_base+2][4:0]) begin
          report_mismatch("commit_o.rd", case_mem[case_base+2], 32'(commit.rd));
          case_errs++;
        end
        if (commit.illegal !== case_mem[case_base+4][0]) begin
          report_mismatch("commit_o.illegal", case_mem[case_base+4], 32'(commit.illegal));
          case_errs++;
        end
        // result only defined for legal encodings
        if (!case_mem[case_base+4][0] && commit.result !== case_mem[case_base+3]) begin
          report_mismatch("commit_o.result", case_mem[case_base+3], commit.result);
          case_errs++;
        end
        $display("case %0d (pc %h): %s", commit_idx, exp_pc,
                 (case_errs == 0) ? "passed" : "failed");
        if (case_errs == 0) begin
          cases_passed = cases_passed + 1;
        end else begin
          cases_failed = cases_failed + 1;
        end
        commit_idx = commit_idx + 1;
      end
    end
  end

  initial begin
    reset_errs   = 0;
    instret_errs = 0;
    timed_out    = 1'b0;
    legal_cases  = 0;
    $readmemh("tb/alu_cases.txt", case_mem);
    for (int i = 0; i < NUM_CASES; i++) begin
      if (case_mem[i*CASE_WORDS+4][0] == 1'b0) begin
        legal_cases++;
      end
    end

    repeat (RESET_CYCLES - 1) begin
      @(negedge clk);
      check_idle_outputs();
    end
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_idle_outputs();
    $display("reset test: %s", (reset_errs == 0) ? "passed" : "failed");

    while (commit_idx < NUM_CASES && cycle_count < MAX_CYCLES) begin
      @(posedge clk);
    end

    if (commit_idx < NUM_CASES) begin
      $display("timeout after %0d cycles, only %0d of %0d cases committed",
               cycle_count, commit_idx, NUM_CASES);
      timed_out = 1'b1;
    end else begin
      // a few more cycles to catch stray commits
      repeat (5) @(negedge clk);
      if (instret !== 64'(legal_cases)) begin
        $display("ERROR %0t: instret_o expected %0d, got %0d", $time, legal_cases, instret);
        instret_errs++;
      end
      $display("instret test: %s", (instret_errs == 0) ? "passed" : "failed");
    end
    if (extra_commits != 0) begin
      $display("%0d commits arrived after the last case", extra_commits);
    end

    $display("summary: %0d passed, %0d failed, %0d reset, %0d fetch, %0d instret errors",
             cases_passed, cases_failed, reset_errs, fetch_errors, instret_errs);
    if (timed_out || reset_errs != 0 || cases_failed != 0 || fetch_errors != 0 ||
        extra_commits != 0 || instret_errs != 0) begin
      $display("Simulation finished: FAIL");
    end else begin
      $display("Simulation finished: PASS");
    end
    $finish;
  end

endmodule

// File: tb/alu_cases.txt
// one instruction per line, all fields in hex
// columns: instruction word, write enable, rd, result, illegal
00500093 1 01 00000005 0
00300113 1 02 00000003 0
002081b3 1 03 00000008 0
40110233 1 04 fffffffe 0
001272b3 1 05 00000004 0
0022e333 1 06 00000007 0
001343b3 1 07 00000002 0
80000437 1 08 80000000 0
01f00493 1 09 0000001f 0
00945533 1 0a 00000001 0
009515b3 1 0b 80000000 0
00009633 1 0c 00000005 0
fff00693 1 0d ffffffff 0
0f06c713 1 0e ffffff0f 0
7ff77793 1 0f 0000070f 0
8007e813 1 10 ffffff0f 0
00708013 1 00 0000000c 0
000008b3 1 11 00000000 0
0000087f 0 10 00000000 1
02208833 0 10 00000000 1
00080993 1 13 ffffff0f 0

// File: all.f
hw/core_pkg.sv
hw/fetch_stage.sv
hw/regfile.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/commit_stage.sv
hw/mini_core.sv
tb/tb_mini_core.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_mini_core
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation finished: FAIL
PASS_MSG  = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
